/* source/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // bypass source for one operand of the instruction in EX.
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    typedef enum logic [2:0] {
        NOP      = 3'd0,
        R_FORMAT = 3'd1,
        I_FORMAT = 3'd2,
        S_FORMAT = 3'd3,
        B_FORMAT = 3'd4,
        U_FORMAT = 3'd5,
        J_FORMAT = 3'd6
    } format_t;

    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    localparam instr_t INSTR_NOP = 32'h0000_0013; // addi x0, x0, 0.

    function automatic opcode_t opcode_of(instr_t instr);
        return instr[6:0];
    endfunction

    function automatic reg_idx_t rd_of(instr_t instr);
        return instr[11:7];
    endfunction

    function automatic reg_idx_t rs1_of(instr_t instr);
        return instr[19:15];
    endfunction

    function automatic reg_idx_t rs2_of(instr_t instr);
        return instr[24:20];
    endfunction

    // jalr is sorted as a jump but still reads its base register.
    function automatic logic uses_rs1(format_t fmt, instr_t instr);
        return (fmt == I_FORMAT) || (fmt == S_FORMAT) || (fmt == R_FORMAT) ||
               (fmt == B_FORMAT) || ((fmt == J_FORMAT) && (opcode_of(instr) == OP_JALR));
    endfunction

    function automatic logic uses_rs2(format_t fmt);
        return (fmt == S_FORMAT) || (fmt == R_FORMAT) || (fmt == B_FORMAT);
    endfunction

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  core_pkg::instr_t  instr_i,
    output core_pkg::format_t format_o,
    output logic              is_load_o,
    output logic              writes_rd_o
);
    import core_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd;

    assign opcode = opcode_of(instr_i);
    assign rd     = rd_of(instr_i);

    always_comb begin
        format_o = NOP;
        if (instr_i != INSTR_NOP) begin // the canonical nop is caught before the opcode.
            case (opcode)
                OP_LOAD, OP_IMM: begin
                    format_o = I_FORMAT;
                end
                OP_REG: begin
                    format_o = R_FORMAT;
                end
                OP_STORE: begin
                    format_o = S_FORMAT;
                end
                OP_BRANCH: begin
                    format_o = B_FORMAT;
                end
                OP_LUI, OP_AUIPC: begin
                    format_o = U_FORMAT;
                end
                OP_JAL, OP_JALR: begin
                    format_o = J_FORMAT;
                end
                default: begin
                    format_o = NOP; // unknown opcodes travel as harmless nops.
                end
            endcase
        end
    end

    assign is_load_o = (format_o == I_FORMAT) && (opcode == OP_LOAD);

    // only formats with an rd field write back, and x0 never counts as a write.
    always_comb begin
        case (format_o)
            R_FORMAT, I_FORMAT, U_FORMAT, J_FORMAT: begin
                writes_rd_o = (rd != '0);
            end
            default: begin
                writes_rd_o = 1'b0;
            end
        endcase
    end

endmodule

/* source/stall_controller.sv */
`timescale 1ns/1ps

module stall_controller (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::instr_t  id_instr_i,
    input  core_pkg::format_t id_format_i,
    input  logic              id_valid_i,
    input  core_pkg::instr_t  ex_instr_i,
    input  logic              ex_is_load_i,
    input  logic              ex_valid_i,
    input  logic              stall_req_i,
    input  logic              unstall_i,
    output logic              stall_o,
    output logic              pipeline_stalled_o
);
    import core_pkg::*;

    logic     stalled_next;
    logic     load_use;
    reg_idx_t ld_rd;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;

    // the sticky stall already counts in the cycle it is requested.
    assign stalled_next = (stall_req_i | pipeline_stalled_o) & ~unstall_i;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            pipeline_stalled_o <= 1'b0;
        end else begin
            pipeline_stalled_o <= stalled_next;
        end
    end

    assign ld_rd  = rd_of(ex_instr_i);
    assign id_rs1 = rs1_of(id_instr_i);
    assign id_rs2 = rs2_of(id_instr_i);

    always_comb begin
        load_use = 1'b0;
        if (id_valid_i && ex_valid_i && ex_is_load_i && (ld_rd != '0)) begin
            if (uses_rs1(id_format_i, id_instr_i) && (id_rs1 == ld_rd)) begin
                load_use = 1'b1;
            end
            if (uses_rs2(id_format_i) && (id_rs2 == ld_rd)) begin
                load_use = 1'b1;
            end
        end
    end

    assign stall_o = stalled_next | load_use;

    // a release always takes effect on the following edge.
    property p_unstall_clears;
        @(posedge clk) disable iff (!rst)
            unstall_i |=> !pipeline_stalled_o;
    endproperty
    a_unstall_clears: assert property (p_unstall_clears)
        else $error("sticky stall survived an unstall request");

    // a nop reads no registers, so only the external stall may hold it.
    property p_nop_no_hazard;
        @(posedge clk) disable iff (!rst)
            (id_valid_i && (id_format_i == NOP) && !stalled_next) |-> !stall_o;
    endproperty
    a_nop_no_hazard: assert property (p_nop_no_hazard)
        else $error("load-use stall raised for a nop in ID");

endmodule

/* source/issue_pipe.sv */
`timescale 1ns/1ps

module issue_pipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid_i,
    input  core_pkg::instr_t   instr_i,
    output logic               instr_ready_o,
    input  logic               stall_i,
    input  logic               id_is_load_i,
    input  logic               id_writes_rd_i,
    input  core_pkg::format_t  id_format_i,
    output logic               id_valid_o,
    output core_pkg::instr_t   id_instr_o,
    output logic               ex_valid_o,
    output core_pkg::instr_t   ex_instr_o,
    output core_pkg::format_t  ex_format_o,
    output logic               ex_is_load_o,
    output core_pkg::reg_idx_t mem_rd_o,
    output logic               mem_wr_o,
    output core_pkg::reg_idx_t wb_rd_o,
    output logic               wb_wr_o
);
    import core_pkg::*;

    logic accept;
    logic id_advance;
    logic ex_wr;

    assign id_advance    = id_valid_o & ~stall_i;
    assign instr_ready_o = ~id_valid_o | ~stall_i; // an empty ID slot takes a word even when stalled.
    assign accept        = instr_valid_i & instr_ready_o;

    // valid bits and write flags.
    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            id_valid_o <= 1'b0;
            ex_valid_o <= 1'b0;
            mem_wr_o   <= 1'b0;
            wb_wr_o    <= 1'b0;
        end else begin
            if (accept) begin
                id_valid_o <= 1'b1;
            end else if (id_advance) begin
                id_valid_o <= 1'b0;
            end
            ex_valid_o <= id_advance; // a stall turns into a bubble here.
            mem_wr_o   <= ex_valid_o & ex_wr;
            wb_wr_o    <= mem_wr_o;
        end
    end

    // instruction words and the decoder flags that ride along with them.
    always_ff @(posedge clk) begin
        if (accept) begin
            id_instr_o <= instr_i;
        end
        if (id_advance) begin
            ex_instr_o   <= id_instr_o;
            ex_format_o  <= id_format_i;
            ex_is_load_o <= id_is_load_i;
            ex_wr        <= id_writes_rd_i;
        end
        mem_rd_o <= rd_of(ex_instr_o);
        wb_rd_o  <= mem_rd_o;
    end

    property p_no_ready_when_held;
        @(posedge clk) disable iff (!rst)
            (stall_i && id_valid_o) |-> !instr_ready_o;
    endproperty
    a_no_ready_when_held: assert property (p_no_ready_when_held)
        else $error("input ready while a stalled word sits in ID");

endmodule

/* source/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
    input  core_pkg::instr_t   ex_instr_i,
    input  core_pkg::format_t  ex_format_i,
    input  logic               ex_valid_i,
    input  core_pkg::reg_idx_t mem_rd_i,
    input  logic               mem_wr_i,
    input  core_pkg::reg_idx_t wb_rd_i,
    input  logic               wb_wr_i,
    output core_pkg::fwd_sel_t fwd_a_o,
    output core_pkg::fwd_sel_t fwd_b_o
);
    import core_pkg::*;

    logic use_a;
    logic use_b;

    // the write flags are never set for x0, so no x0 check is needed here.
    function automatic fwd_sel_t pick_source(
        input reg_idx_t rs,
        input logic     used,
        input reg_idx_t mem_rd,
        input logic     mem_wr,
        input reg_idx_t wb_rd,
        input logic     wb_wr
    );
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (used) begin
            if (mem_wr && (mem_rd == rs)) begin
                sel = FWD_MEM; // the younger result wins.
            end else if (wb_wr && (wb_rd == rs)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign use_a = ex_valid_i && uses_rs1(ex_format_i, ex_instr_i);
    assign use_b = ex_valid_i && uses_rs2(ex_format_i);

    always_comb begin
        fwd_a_o = pick_source(rs1_of(ex_instr_i), use_a, mem_rd_i, mem_wr_i, wb_rd_i, wb_wr_i);
        fwd_b_o = pick_source(rs2_of(ex_instr_i), use_b, mem_rd_i, mem_wr_i, wb_rd_i, wb_wr_i);
    end

    always_comb begin
        assert final ((fwd_a_o != 2'd3) && (fwd_b_o != 2'd3))
            else $error("bypass select took the unused code 3");
    end

endmodule

/* source/pipe_hazard_top.sv */
`timescale 1ns/1ps

module pipe_hazard_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid_i,
    input  core_pkg::instr_t   instr_i,
    output logic               instr_ready_o,
    input  logic               stall_req_i,
    input  logic               unstall_i,
    output logic               ex_valid_o,
    output core_pkg::instr_t   ex_instr_o,
    output core_pkg::fwd_sel_t fwd_a_o,
    output core_pkg::fwd_sel_t fwd_b_o,
    output logic               stall_o,
    output logic               pipeline_stalled_o
);
    import core_pkg::*;

    format_t  id_format;
    logic     id_is_load;
    logic     id_writes_rd;
    logic     id_valid;
    instr_t   id_instr;
    format_t  ex_format;
    logic     ex_is_load;
    reg_idx_t mem_rd;
    logic     mem_wr;
    reg_idx_t wb_rd;
    logic     wb_wr;

    issue_pipe issue_pipe_inst (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .stall_i        (stall_o),
        .id_is_load_i   (id_is_load),
        .id_writes_rd_i (id_writes_rd),
        .id_format_i    (id_format),
        .id_valid_o     (id_valid),
        .id_instr_o     (id_instr),
        .ex_valid_o     (ex_valid_o),
        .ex_instr_o     (ex_instr_o),
        .ex_format_o    (ex_format),
        .ex_is_load_o   (ex_is_load),
        .mem_rd_o       (mem_rd),
        .mem_wr_o       (mem_wr),
        .wb_rd_o        (wb_rd),
        .wb_wr_o        (wb_wr)
    );

    instr_decoder instr_decoder_inst (
        .instr_i     (id_instr),
        .format_o    (id_format),
        .is_load_o   (id_is_load),
        .writes_rd_o (id_writes_rd)
    );

    stall_controller stall_controller_inst (
        .clk                (clk),
        .rst                (rst),
        .id_instr_i         (id_instr),
        .id_format_i        (id_format),
        .id_valid_i         (id_valid),
        .ex_instr_i         (ex_instr_o),
        .ex_is_load_i       (ex_is_load),
        .ex_valid_i         (ex_valid_o),
        .stall_req_i        (stall_req_i),
        .unstall_i          (unstall_i),
        .stall_o            (stall_o),
        .pipeline_stalled_o (pipeline_stalled_o)
    );

    forward_unit forward_unit_inst (
        .ex_instr_i  (ex_instr_o),
        .ex_format_i (ex_format),
        .ex_valid_i  (ex_valid_o),
        .mem_rd_i    (mem_rd),
        .mem_wr_i    (mem_wr),
        .wb_rd_i     (wb_rd),
        .wb_wr_i     (wb_wr),
        .fwd_a_o     (fwd_a_o),
        .fwd_b_o     (fwd_b_o)
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    // reset is held for 16 rising edges and released just after the last one.
    initial begin
        rst = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

/* bench/pipe_hazard_tb.sv */
`timescale 1ns/1ps

module pipe_hazard_tb;
    import core_pkg::*;

    localparam int NUM_INSTR      = 1500;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 500;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr_word;
    logic        instr_ready;
    logic        stall_req;
    logic        unstall;
    logic        ex_valid;
    logic [31:0] ex_instr;
    logic [1:0]  fwd_a;
    logic [1:0]  fwd_b;
    logic        stall;
    logic        pipeline_stalled;

    logic [31:0] prog [NUM_INSTR];
    logic [31:0] rng;
    logic        taken;
    logic [31:0] acc_word_q[$];
    int          acc_cycle_q[$];
    int          cycle;
    int          sent;
    int          retired;
    int          check_count;
    int          error_count;
    int          load_use_count;
    int          sticky_cycles;

    // model of the pipe slots.
    logic        m_id_v;
    logic [31:0] m_id_w;
    int          m_id_hold;
    logic        m_ex_v;
    logic [31:0] m_ex_w;
    int          m_ex_hold;
    logic        m_mem_wr;
    logic [4:0]  m_mem_rd;
    logic        m_wb_wr;
    logic [4:0]  m_wb_rd;
    logic        m_sticky;

    clock_gen clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    pipe_hazard_top pipe_hazard_top_inst (
        .clk                (clk),
        .rst                (rst),
        .instr_valid_i      (instr_valid),
        .instr_i            (instr_word),
        .instr_ready_o      (instr_ready),
        .stall_req_i        (stall_req),
        .unstall_i          (unstall),
        .ex_valid_o         (ex_valid),
        .ex_instr_o         (ex_instr),
        .fwd_a_o            (fwd_a),
        .fwd_b_o            (fwd_b),
        .stall_o            (stall),
        .pipeline_stalled_o (pipeline_stalled)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // registers come from x0..x3 so that dependencies are common.
    function automatic logic [31:0] make_instr(input logic [31:0] r);
        logic [6:0] op;
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: op = OP_LOAD;
            4'd4:    op = OP_IMM;
            4'd7:    op = OP_STORE;
            4'd8:    op = OP_BRANCH;
            4'd9:    op = OP_LUI;
            4'd10:   op = OP_AUIPC;
            4'd11:   op = OP_JAL;
            4'd12:   op = OP_JALR;
            4'd14:   op = 7'b0001111; // fence, outside the decoded set.
            default: op = OP_REG;
        endcase
        if (r[3:0] == 4'd13) begin
            return 32'h0000_0013;
        end
        return {r[31:25], 3'b000, r[9:8], 3'b000, r[7:6], r[14:12], 3'b000, r[5:4], op};
    endfunction

    function automatic format_t classify(input logic [31:0] w);
        format_t f;
        case (w[6:0])
            OP_LOAD, OP_IMM:  f = I_FORMAT;
            OP_REG:           f = R_FORMAT;
            OP_STORE:         f = S_FORMAT;
            OP_BRANCH:        f = B_FORMAT;
            OP_LUI, OP_AUIPC: f = U_FORMAT;
            OP_JAL, OP_JALR:  f = J_FORMAT;
            default:          f = NOP;
        endcase
        if (w == 32'h0000_0013) begin
            f = NOP;
        end
        return f;
    endfunction

    function automatic logic reads_rs1(input logic [31:0] w);
        format_t f;
        f = classify(w);
        return (f == I_FORMAT) || (f == S_FORMAT) || (f == R_FORMAT) || (f == B_FORMAT) ||
               ((f == J_FORMAT) && (w[6:0] == OP_JALR));
    endfunction

    function automatic logic reads_rs2(input logic [31:0] w);
        format_t f;
        f = classify(w);
        return (f == S_FORMAT) || (f == R_FORMAT) || (f == B_FORMAT);
    endfunction

    function automatic logic writes_reg(input logic [31:0] w);
        format_t f;
        f = classify(w);
        return ((f == R_FORMAT) || (f == I_FORMAT) || (f == U_FORMAT) || (f == J_FORMAT)) &&
               (w[11:7] != 5'd0);
    endfunction

    function automatic logic [1:0] expect_sel(input logic used, input logic [4:0] rs);
        logic [1:0] sel;
        sel = FWD_NONE;
        if (used && m_mem_wr && (m_mem_rd == rs)) begin
            sel = FWD_MEM;
        end else if (used && m_wb_wr && (m_wb_rd == rs)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        rng = xorshift(rng);
        r   = rng;
        if (!instr_valid || taken) begin
            if ((sent < NUM_INSTR) && (r[2:0] != 3'd0)) begin
                instr_valid = 1'b1;
                instr_word  = prog[sent];
            end else begin
                instr_valid = 1'b0;
                instr_word  = xorshift(r); // junk that must never be taken.
            end
        end
        taken = 1'b0;
        if (sent < NUM_INSTR) begin
            stall_req = (r[12:8] == 5'd0);
            unstall   = (r[15:13] == 3'd0);
        end else begin
            stall_req = 1'b0;
            unstall   = 1'b1;
        end
    endtask

    task automatic check_and_step();
        logic        sticky_next;
        logic        load_use;
        logic        exp_stall;
        logic        accept;
        logic        advance;
        logic [4:0]  ld_rd;
        logic [31:0] front_word;
        int          front_cycle;

        ld_rd       = m_ex_w[11:7];
        sticky_next = (stall_req || m_sticky) && !unstall; // unstall wins over a request.
        load_use    = m_id_v && m_ex_v && (m_ex_w[6:0] == OP_LOAD) && (ld_rd != 5'd0) &&
                      ((reads_rs1(m_id_w) && (m_id_w[19:15] == ld_rd)) ||
                       (reads_rs2(m_id_w) && (m_id_w[24:20] == ld_rd)));
        exp_stall   = sticky_next || load_use;

        check_value("stall_o", stall, exp_stall);
        check_value("pipeline_stalled_o", pipeline_stalled, m_sticky);
        check_value("instr_ready_o", instr_ready, !m_id_v || !exp_stall);
        check_value("ex_valid_o", ex_valid, m_ex_v);
        if (m_ex_v) begin
            check_value("ex_instr_o", ex_instr, m_ex_w);
        end
        check_value("fwd_a_o", fwd_a, expect_sel(m_ex_v && reads_rs1(m_ex_w), m_ex_w[19:15]));
        check_value("fwd_b_o", fwd_b, expect_sel(m_ex_v && reads_rs2(m_ex_w), m_ex_w[24:20]));

        if (ex_valid) begin
            if (acc_word_q.size() == 0) begin
                error_count++;
                $display("ERROR at %0t: an instruction reached EX that was never accepted", $time);
            end else begin
                front_word  = acc_word_q.pop_front();
                front_cycle = acc_cycle_q.pop_front();
                check_value("ex_instr_o order", ex_instr, front_word);
                check_value("ex latency", cycle - front_cycle, 2 + m_ex_hold);
                retired++;
            end
        end
        if (load_use && !sticky_next) begin
            load_use_count++;
        end
        if (m_sticky) begin
            sticky_cycles++;
        end

        // advance the model by one edge.
        accept   = instr_valid && instr_ready;
        advance  = m_id_v && !exp_stall;
        m_wb_wr  = m_mem_wr;
        m_wb_rd  = m_mem_rd;
        m_mem_wr = m_ex_v && writes_reg(m_ex_w);
        m_mem_rd = m_ex_w[11:7];
        m_ex_v   = advance;
        if (advance) begin
            m_ex_w    = m_id_w;
            m_ex_hold = m_id_hold;
        end
        if (m_id_v && exp_stall) begin
            m_id_hold++;
        end
        if (accept) begin
            m_id_v    = 1'b1;
            m_id_w    = instr_word;
            m_id_hold = 0;
            acc_word_q.push_back(instr_word);
            acc_cycle_q.push_back(cycle);
            sent++;
            taken = 1'b1;
        end else if (advance) begin
            m_id_v = 1'b0;
        end
        m_sticky = sticky_next;
    endtask

    initial begin : stimulus
        int tail;

        instr_valid = 1'b0;
        instr_word  = '0;
        stall_req   = 1'b0;
        unstall     = 1'b0;
        rng         = 32'hb442;
        taken       = 1'b0;
        {cycle, sent, retired, check_count, error_count} = '0;
        {load_use_count, sticky_cycles, tail} = '0;
        {m_id_v, m_ex_v, m_mem_wr, m_wb_wr, m_sticky} = '0;
        {m_id_w, m_ex_w, m_mem_rd, m_wb_rd} = '0;
        m_id_hold = 0;
        m_ex_hold = 0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            rng     = xorshift(rng);
            prog[i] = make_instr(rng);
        end

        repeat (8) @(posedge clk);
        #6;
        check_value("ex_valid_o", ex_valid, 1'b0);
        check_value("pipeline_stalled_o", pipeline_stalled, 1'b0);
        check_value("instr_ready_o", instr_ready, 1'b1);
        check_value("fwd_a_o", fwd_a, FWD_NONE);
        check_value("fwd_b_o", fwd_b, FWD_NONE);
        wait (rst === 1'b1);

        // outputs are sampled 6 ns after the edge, once the 1 ns drive has settled.
        while ((tail < 4) && (cycle < TIMEOUT_CYCLES)) begin
            @(posedge clk);
            #1;
            cycle++;
            drive_inputs();
            #5;
            check_and_step();
            if ((retired == NUM_INSTR) && !m_id_v && !m_ex_v) begin
                tail++;
            end
        end

        if (tail < 4) begin
            error_count++;
            $display("ERROR: timeout after %0d cycles, %0d of %0d instructions reached EX",
                     cycle, retired, NUM_INSTR);
        end
        if ((retired != NUM_INSTR) || (acc_word_q.size() != 0)) begin
            error_count++;
            $display("ERROR: %0d accepted instructions never reached EX", acc_word_q.size());
        end
        $display("checks=%0d errors=%0d retired=%0d load_use_stalls=%0d sticky_cycles=%0d",
                 check_count, error_count, retired, load_use_count, sticky_cycles);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* pipe_hazard.f */
source/core_pkg.sv
source/instr_decoder.sv
source/stall_controller.sv
source/issue_pipe.sv
source/forward_unit.sv
source/pipe_hazard_top.sv
bench/clock_gen.sv
bench/pipe_hazard_tb.sv
